// File: logic/icache_pkg.sv
/*
  shared geometry and types for the read-only instruction cache
  fixed at 2 ways x 64 sets x 16-byte lines on 32-bit addresses
  changing the geometry means revisiting the field positions below
*/
`default_nettype none

package icache_pkg;

  localparam int NUM_WAYS     = 2;
  localparam int NUM_SETS     = 64;
  localparam int WORD_W       = 64;   // fetch word and memory beat

  // address field positions
  localparam int TAG_LSB      = 10;
  localparam int INDEX_LSB    = 4;
  localparam int WORD_SEL_BIT = 3;    // picks low/high half of a line

  typedef logic [31:0]                  addr_t;
  typedef logic [31:TAG_LSB]            tag_t;
  typedef logic [TAG_LSB-INDEX_LSB-1:0] index_t;
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [2*WORD_W-1:0]          line_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]  way_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,   // ways hold the read, hit is valid
    MEM_AR,   // line request waiting for memory
    MEM_R,    // taking the two beats
    RESP      // response held until consumed
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: logic/icache_way.sv
/*
  one cache way: tag, valid and data arrays for every set
  data is read synchronously on rd_en_i, hit compares against the
  index and tag captured on that same edge
  fills use lookup_index_i/lookup_tag_i, held stable by the controller
*/
`timescale 1ns/1ps
`default_nettype none

module icache_way import icache_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   rd_en_i,
  input  wire index_t lookup_index_i,
  input  wire tag_t   lookup_tag_i,
  input  wire logic   fill_en_i,
  input  wire logic   fill_beat_i,
  input  wire word_t  fill_data_i,
  input  wire logic   fill_done_i,
  output logic        hit_o,
  output line_t       line_o
);

  tag_t  tag_mem [NUM_SETS];
  word_t data_lo [NUM_SETS];   // line bits 63:0, beat 0
  word_t data_hi [NUM_SETS];   // line bits 127:64, beat 1

  logic [NUM_SETS-1:0] valid_q;

  index_t idx_q;
  tag_t   tag_q;
  line_t  line_q;

  // lookup capture and sync data read
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      idx_q  <= lookup_index_i;
      tag_q  <= lookup_tag_i;
      line_q <= {data_hi[lookup_index_i], data_lo[lookup_index_i]};
    end
  end

  // fill writes
  // the low-half pulse also covers the lookup-miss cycle, where the tag goes in
  always_ff @(posedge clk) begin
    if (fill_en_i) begin
      if (fill_beat_i) begin
        data_hi[lookup_index_i] <= fill_data_i;
      end else begin
        data_lo[lookup_index_i] <= fill_data_i;  // overwritten again by beat 0
        tag_mem[lookup_index_i] <= lookup_tag_i;
      end
    end
  end

  // valid drops on the first fill pulse and comes back with the last beat
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_en_i) begin
      valid_q[lookup_index_i] <= fill_done_i;
    end
  end

  assign hit_o  = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);
  assign line_o = line_q;

endmodule

`default_nettype wire

// File: logic/icache_way_sel.sv
/*
  picks the hitting way and the requested 64-bit half of its line
  hits are expected one-hot or zero, word_o is don't-care without a hit
*/
`timescale 1ns/1ps
`default_nettype none

module icache_way_sel import icache_pkg::*; (
  input  wire logic [NUM_WAYS-1:0] hit_i,
  input  wire line_t               line_i [NUM_WAYS],
  input  wire logic                word_sel_i,
  output logic                     any_hit_o,
  output word_t                    word_o
);

  way_t  hit_way;
  line_t hit_line;

  // one-hot to way number
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_i[w]) hit_way = way_t'(w);
    end
  end

  assign hit_line  = line_i[hit_way];
  assign any_hit_o = |hit_i;
  assign word_o    = word_sel_i ? hit_line[2*WORD_W-1:WORD_W]  // upper half
                                : hit_line[WORD_W-1:0];

  // a line must never live in two ways of one set
  always_comb begin
    if (!$isunknown(hit_i)) begin
      multi_hit_a: assert final ($onehot0(hit_i))
        else $error("icache: more than one way hit, hit=%b", hit_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/icache_ctrl.sv
/*
  request/refill FSM for the instruction cache
  one request outstanding at a time with req_ready_o only in IDLE
  a miss fetches the whole line as two beats with the low word first
  victim way comes from a free-running counter rather than LRU
*/
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst,
  // fetch side
  input  wire logic   req_valid_i,
  output logic        req_ready_o,
  input  wire addr_t  req_addr_i,
  output logic        rsp_valid_o,
  input  wire logic   rsp_ready_i,
  output word_t       rsp_data_o,
  // memory side
  output logic        mem_ar_valid_o,
  input  wire logic   mem_ar_ready_i,
  output addr_t       mem_ar_addr_o,
  input  wire logic   mem_r_valid_i,
  output logic        mem_r_ready_o,
  input  wire word_t  mem_r_data_i,
  // to the ways
  output index_t      lookup_index_o,
  output tag_t        lookup_tag_o,
  output logic        rd_en_o,
  output logic [NUM_WAYS-1:0] fill_en_o,
  output logic        fill_beat_o,
  output word_t       fill_data_o,
  output logic        fill_done_o,
  // from the way selector
  input  wire logic   any_hit_i,
  input  wire word_t  sel_word_i,
  output logic        word_sel_o
);

  ctrl_state_e state, state_nxt;

  addr_t addr_q;      // captured request
  way_t  repl_cnt;
  way_t  victim_q;
  way_t  victim;
  logic  beat_q;      // 0 = low half expected next
  word_t rsp_data_q;

  logic req_fire;
  logic lookup_miss;
  logic beat_take;
  logic fill_fire;

  logic [1:0] burst_beats;  // beats since the line request

  assign req_fire    = req_valid_i && req_ready_o;
  assign lookup_miss = (state == LOOKUP) && !any_hit_i;
  assign beat_take   = mem_r_valid_i && mem_r_ready_o;
  assign fill_fire   = lookup_miss || beat_take;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (req_fire) state_nxt = LOOKUP;
      LOOKUP:  state_nxt = any_hit_i ? RESP : MEM_AR;
      MEM_AR:  if (mem_ar_ready_i) state_nxt = MEM_R;
      MEM_R:   if (beat_take && beat_q) state_nxt = RESP;
      RESP:    if (rsp_ready_i) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      repl_cnt <= '0;
      beat_q   <= 1'b0;
    end else begin
      state    <= state_nxt;
      repl_cnt <= repl_cnt + 1'b1;  // free-running
      if (beat_take) beat_q <= ~beat_q;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) addr_q <= req_addr_i;
    if (lookup_miss) victim_q <= repl_cnt;
    if ((state == LOOKUP) && any_hit_i) rsp_data_q <= sel_word_i;
    // keep only the beat that matches the requested half
    if (beat_take && (beat_q == addr_q[WORD_SEL_BIT])) rsp_data_q <= mem_r_data_i;
  end

  // in IDLE the ways look at the incoming address and afterwards at the held one
  assign lookup_index_o = (state == IDLE) ? req_addr_i[TAG_LSB-1:INDEX_LSB]
                                          : addr_q[TAG_LSB-1:INDEX_LSB];
  assign lookup_tag_o   = (state == IDLE) ? req_addr_i[31:TAG_LSB] : addr_q[31:TAG_LSB];
  assign rd_en_o        = req_fire;
  assign word_sel_o     = addr_q[WORD_SEL_BIT];

  assign victim = (state == LOOKUP) ? repl_cnt : victim_q;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      fill_en_o[w] = fill_fire && (victim == way_t'(w));
    end
  end

  assign fill_beat_o = beat_q;       // low in LOOKUP too
  assign fill_data_o = mem_r_data_i;
  assign fill_done_o = beat_take && beat_q;

  assign req_ready_o    = (state == IDLE);
  assign rsp_valid_o    = (state == RESP);
  assign rsp_data_o     = rsp_data_q;
  assign mem_ar_valid_o = (state == MEM_AR);
  assign mem_ar_addr_o  = {addr_q[31:INDEX_LSB], {INDEX_LSB{1'b0}}};  // line aligned
  assign mem_r_ready_o  = (state == MEM_R);

  always_ff @(posedge clk) begin
    if (rst || (mem_ar_valid_o && mem_ar_ready_i)) begin
      burst_beats <= '0;
    end else if (beat_take) begin
      burst_beats <= burst_beats + 1'b1;
    end
  end

  // line request holds until memory takes it
  ar_hold_a: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o));

  // never more than two beats per line request
  two_beats_a: assert property (@(posedge clk) disable iff (rst)
    beat_take |-> burst_beats < 2'd2);

endmodule

`default_nettype wire

// File: logic/icache_top.sv
/*
  read-only 2-way instruction cache, 2 KiB, 16-byte lines
  fetch side and memory side are plain valid/ready pairs
  hit latency is 2 cycles, a miss fetches one 2-beat line burst
*/
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  req_valid_i,
  output logic       req_ready_o,
  input  wire addr_t req_addr_i,
  output logic       rsp_valid_o,
  input  wire logic  rsp_ready_i,
  output word_t      rsp_data_o,
  output logic       mem_ar_valid_o,
  input  wire logic  mem_ar_ready_i,
  output addr_t      mem_ar_addr_o,
  input  wire logic  mem_r_valid_i,
  output logic       mem_r_ready_o,
  input  wire word_t mem_r_data_i
);

  index_t lookup_index;
  tag_t   lookup_tag;
  logic   rd_en;
  logic [NUM_WAYS-1:0] fill_en;
  logic   fill_beat;
  word_t  fill_data;
  logic   fill_done;
  logic [NUM_WAYS-1:0] way_hit;
  line_t  way_line [NUM_WAYS];
  logic   any_hit;
  word_t  sel_word;
  logic   word_sel;

  icache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_addr_i     (req_addr_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_data_o     (rsp_data_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .rd_en_o        (rd_en),
    .fill_en_o      (fill_en),
    .fill_beat_o    (fill_beat),
    .fill_data_o    (fill_data),
    .fill_done_o    (fill_done),
    .any_hit_i      (any_hit),
    .sel_word_i     (sel_word),
    .word_sel_o     (word_sel)
  );

  // lookup and fill buses go to every way, fill_en picks the victim
  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    icache_way u_way (
      .clk            (clk),
      .rst            (rst),
      .rd_en_i        (rd_en),
      .lookup_index_i (lookup_index),
      .lookup_tag_i   (lookup_tag),
      .fill_en_i      (fill_en[g]),
      .fill_beat_i    (fill_beat),
      .fill_data_i    (fill_data),
      .fill_done_i    (fill_done),
      .hit_o          (way_hit[g]),
      .line_o         (way_line[g])
    );
  end

  icache_way_sel u_way_sel (
    .hit_i      (way_hit),
    .line_i     (way_line),
    .word_sel_i (word_sel),
    .any_hit_o  (any_hit),
    .word_o     (sel_word)
  );

endmodule

`default_nettype wire

// File: tb/icache_mem_model.sv
/*
  behavioral line memory for the cache testbench
  answers one burst at a time, two beats low word first
  stall_i holds off ar_ready_o and r_valid_o for that cycle
*/
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model import icache_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  stall_i,
  input  wire logic  ar_valid_i,
  output logic       ar_ready_o,
  input  wire addr_t ar_addr_i,
  output logic       r_valid_o,
  input  wire logic  r_ready_i,
  output word_t      r_data_o
);

  logic  busy;
  logic  beat;        // next beat to send
  logic  stall;
  addr_t line_addr;

  // contents: the word's own byte address, mixed
  function automatic word_t mem_word(input addr_t addr);
    addr_t half;
    half = {addr[31:4], addr[3], 3'b000};
    return {half ^ 32'h9e37_79b9, ~half};
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    busy       = 1'b0;
    beat       = 1'b0;
    line_addr  = '0;
  end

  always @(posedge clk) begin
    stall = stall_i;      // sampled with the handshakes
    if (rst) begin
      busy = 1'b0;
      beat = 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      busy      = 1'b1;
      beat      = 1'b0;
      line_addr = ar_addr_i;
    end else if (r_valid_o && r_ready_i) begin
      busy = !beat;       // done after beat 1
      beat = !beat;
    end
    #1;
    ar_ready_o = !busy && !stall && !rst;
    r_valid_o  = busy && !stall;
    r_data_o   = mem_word({line_addr[31:4], beat, 3'b000});
  end

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
/*
  testbench for the instruction cache with random stalls on both sides
  expected words come from mem_word and hit or miss from memory traffic
  pool[0..2] share one set index
*/
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*;;

  localparam int N_REQ      = 120;
  localparam int SETTLE_MAX = 32;
  localparam int N_ALT      = 16;
  localparam int LIMIT      = (2 * N_REQ + 2 * (SETTLE_MAX + N_ALT)) * 40 + 100;

  logic clk, rst, req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i, mem_stall;
  logic mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  addr_t req_addr_i, mem_ar_addr_o, cur_addr;
  word_t rsp_data_o, mem_r_data_i, held_data;
  logic  hold_pending = 1'b0;
  logic [31:0] lfsr   = 32'h1efee1f5;
  logic [7:0]  seen   = '0;
  int ar_cnt, beat_cnt, cycles = 0;
  addr_t pool [8] = '{32'h0000_0050, 32'h0000_0450, 32'h0001_2850, 32'h0000_0100,
                      32'h0000_0230, 32'h8000_0ff0, 32'h0000_1360, 32'h0040_0070};

  icache_top uut (.*);

  icache_mem_model u_mem (
    .clk(clk), .rst(rst), .stall_i(mem_stall),
    .ar_valid_i(mem_ar_valid_o), .ar_ready_o(mem_ar_ready_i), .ar_addr_i(mem_ar_addr_o),
    .r_valid_o(mem_r_valid_i), .r_ready_i(mem_r_ready_o), .r_data_o(mem_r_data_i)
  );

  function automatic word_t mem_word(input addr_t addr);
    addr_t half;
    half = {addr[31:4], addr[3], 3'b000};
    return {half ^ 32'h9e37_79b9, ~half};
  endfunction

  // galois lfsr stepped once per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_int(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // starts at a rising edge and returns at the edge the response is taken
  task automatic fetch(input addr_t addr, output logic missed);
    int lat;
    int rsp_lat;
    logic done;
    lat = 0;
    rsp_lat = 0;
    done = 1'b0;
    #1;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    cur_addr    = addr;
    do @(posedge clk); while (!req_ready_o);
    ar_cnt   = 0;
    beat_cnt = 0;
    #1;
    req_valid_i = 1'b0;
    while (!done) begin
      @(posedge clk);
      lat++;
      check_bit("req_ready_o", req_ready_o, 1'b0);
      if (rsp_valid_o && rsp_lat == 0) rsp_lat = lat;
      done = rsp_valid_o && rsp_ready_i;
    end
    check_word("rsp_data_o", rsp_data_o, mem_word(addr));
    missed = (ar_cnt != 0);
    if (missed) begin
      check_int("mem_ar requests", ar_cnt, 1);
      check_int("mem_r beats", beat_cnt, 2);
    end else begin
      check_int("hit latency", rsp_lat, 2);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // memory stalls 1 in 4 cycles and rsp_ready_i is low 1 in 4
  initial begin
    mem_stall   = 1'b0;
    rsp_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      mem_stall   = (rand_bits(2) == 8'd3);
      rsp_ready_i = (rand_bits(2) != 8'd0);
    end
  end

  always @(posedge clk) begin
    if (mem_ar_valid_o && mem_ar_ready_i) begin
      ar_cnt++;
      check_addr("mem_ar_addr_o", mem_ar_addr_o, {cur_addr[31:4], 4'h0});
    end
    if (mem_r_valid_i && mem_r_ready_o) beat_cnt++;
    if (!rst && hold_pending) begin   // back-pressure hold
      check_bit("rsp_valid_o", rsp_valid_o, 1'b1);
      check_word("rsp_data_o held", rsp_data_o, held_data);
    end
    hold_pending = rsp_valid_o && !rsp_ready_i;
    held_data    = rsp_data_o;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles > LIMIT);
    $display("timeout: run still busy after %0d cycles", cycles);
    $display("TEST FAIL");
    $fatal(1, "simulation timed out");
  end

  initial begin
    logic [2:0] pick;
    addr_t addr;
    logic m0, m1;
    int rounds;
    int misses;
    rst = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    cur_addr    = '0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("mem_ar_valid_o", mem_ar_valid_o, 1'b0);
    check_bit("mem_r_ready_o", mem_r_ready_o, 1'b0);

    for (int n = 0; n < N_REQ; n++) begin
      pick = 3'(rand_bits(3));
      addr = pool[pick] | (addr_t'(rand_bits(1)) << 3);
      fetch(addr, m0);
      if (!seen[pick]) check_bit("first access missed", m0, 1'b1);
      seen[pick] = 1'b1;
      if (m0) begin
        fetch(addr ^ 32'h8, m1);  // the other half has to hit
        check_bit("miss after fill", m1, 1'b0);
      end
    end

    // get two same-set lines resident together and then alternate
    rounds = 0;
    do begin
      fetch(pool[0], m0);
      fetch(pool[1], m1);
      rounds++;
    end while ((m0 || m1) && rounds < SETTLE_MAX);
    if (m0 || m1) begin
      $display("two lines of one set never resident together after %0d rounds", rounds);
      stop_on_error();
    end
    misses = 0;
    for (int n = 0; n < N_ALT; n++) begin
      fetch(pool[0] | (addr_t'(rand_bits(1)) << 3), m0);
      fetch(pool[1] | (addr_t'(rand_bits(1)) << 3), m1);
      misses += m0 + m1;
    end
    check_int("memory requests while alternating", misses, 0);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/icache_pkg.sv
logic/icache_way.sv
logic/icache_way_sel.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv
